/* bench/muladd_tests.txt */
// id | units 0..3, each: sela selb opcode shift | period iterations delay (all hex)
// opcode 0 macc, 1 msub, 2 accumulate without reload; id ff ends the list
// basic macc, each unit with its own operand pair
01  0 1 0 0  2 3 0 0  1 1 0 0  3 0 0 0  4 03 0
// msub mixed with macc
02  0 1 1 0  1 2 1 0  2 3 0 0  3 3 1 0  5 02 2
// same operands, shifts 0 3 8 f
03  0 1 0 0  0 1 0 3  0 1 0 8  0 1 0 f  2 04 1
// zero iterations, results must not move
04  1 0 0 2  0 2 1 1  3 1 0 4  2 2 1 0  3 00 3
// delayed start
05  3 2 0 1  2 1 0 0  1 0 0 5  0 3 0 2  6 05 7
// back to back, period one msub
06  2 2 1 0  3 1 1 6  0 0 1 0  1 2 1 3  1 09 f
// long run
07  0 3 0 0  1 2 0 0  2 1 1 0  3 0 1 0  f 14 0
// no reload opcode builds on the previous value
08  1 1 2 0  0 2 0 1  3 3 2 2  2 0 1 0  3 02 4
ff  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 00 0

/* filelist.f */
src/cgra_pkg.sv
src/array_feed.sv
src/pace_counter.sv
src/mul_pipe.sv
src/muladd_unit.sv
src/flow_collector.sv
src/muladd_array.sv
bench/muladd_array_chk.sv
bench/muladd_array_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f --top-module muladd_array_tb -o muladd_sim
./obj_dir/muladd_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
   echo "simulation result: pass"
else
   echo "simulation result: fail"
   exit 1
fi

/* bench/muladd_array_tb.sv */
`default_nettype none

module muladd_array_tb;
   import cgra_pkg::*;

   localparam int data_w    = 16;
   localparam int n_units   = 4;
   localparam int n_cols    = 4*n_units + 4;   // id, 4 fields per unit, period, iters, delay
   localparam int max_tests = 32;
   localparam logic [7:0] end_id = 8'hff;

   logic                      clk = 1'b0;
   logic                      rst;
   logic                      start;
   logic [n_units*data_w-1:0] op_in;
   logic                      cfg_wr;
   logic [sel_w-1:0]          cfg_unit;
   logic [cfg_w-1:0]          cfg_data;
   logic [n_units*data_w-1:0] result;
   logic                      done;

   logic [7:0]          test_mem [0:max_tests*n_cols-1];
   logic [31:0]         seed;
   logic [data_w-1:0]   ops [n_units];
   logic [2*data_w-1:0] exp_acc [n_units];   // model accumulators
   int                  n_tests;
   int                  cycle_cnt   = 0;
   int                  cycle_limit = 0;
   int                  checks      = 0;
   int                  errors      = 0;

   muladd_array #(
      .DATA_W  (data_w),
      .N_UNITS (n_units)
   ) UUT (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .op_in    (op_in),
      .cfg_wr   (cfg_wr),
      .cfg_unit (cfg_unit),
      .cfg_data (cfg_data),
      .result   (result),
      .done     (done)
   );

   always #5 clk = ~clk;

   // watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int test_field(input int t, input int col);
      return int'(test_mem[t*n_cols + col]);
   endfunction

   // fields packed from the top bit down as sela selb opcode iterations period delay shift
   function automatic logic [cfg_w-1:0] make_cfg(input int sela, input int selb,
      input int op, input int iters, input int period, input int delay, input int shift);
      return {sel_w'(sela), sel_w'(selb), op_w'(op), iter_w'(iters),
              period_w'(period), period_w'(delay), shift_w'(shift)};
   endfunction

   // signed a*b widened to the accumulator and shifted left
   function automatic logic [2*data_w-1:0] shifted_product(input logic [data_w-1:0] a,
      input logic [data_w-1:0] b, input int shift);
      logic [2*data_w-1:0] a_ext;
      logic [2*data_w-1:0] b_ext;
      a_ext = {{data_w{a[data_w-1]}}, a};
      b_ext = {{data_w{b[data_w-1]}}, b};
      return (a_ext * b_ext) << shift;
   endfunction

   function automatic logic [data_w-1:0] pick_op(input int sel);
      return ops[sel];
   endfunction

   task automatic write_cfg(input int unit, input logic [cfg_w-1:0] word);
      @(negedge clk);
      cfg_wr   = 1'b1;
      cfg_unit = sel_w'(unit);
      cfg_data = word;
      @(negedge clk);
      cfg_wr   = 1'b0;
   endtask

   // cycles from the start pulse until done is seen
   task automatic pulse_and_wait(output int waited);
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start  = 1'b0;
      waited = 1;
      while (!(waited > 2 && done)) begin   // done of the last test is still up right after the pulse
         @(negedge clk);
         waited++;
      end
   endtask

   initial begin
      int id;
      int period;
      int iters;
      int delay;
      int waited;
      int exp_wait;
      int bad;
      int op;
      logic [2*data_w-1:0] p;
      logic [data_w-1:0]   got;

      rst      = 1'b1;
      start    = 1'b0;
      op_in    = '0;
      cfg_wr   = 1'b0;
      cfg_unit = '0;
      cfg_data = '0;
      seed     = 32'h39117abd;
      for (int u = 0; u < n_units; u++) begin
         exp_acc[u] = '0;
         ops[u]     = '0;
      end

      $readmemh("bench/muladd_tests.txt", test_mem);
      n_tests = 0;
      while (n_tests < max_tests && test_mem[n_tests*n_cols] != end_id) begin
         cycle_limit = cycle_limit + test_field(n_tests, n_cols-1)
                     + test_field(n_tests, n_cols-3) * test_field(n_tests, n_cols-2) + 40;
         n_tests++;
      end

      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int t = 0; t < n_tests; t++) begin
         id       = test_field(t, 0);
         period   = test_field(t, 4*n_units + 1);
         iters    = test_field(t, 4*n_units + 2);
         delay    = test_field(t, 4*n_units + 3);
         exp_wait = delay + period*iters + 5;
         bad      = 0;

         // operands stay put for the whole test
         @(negedge clk);
         for (int u = 0; u < n_units; u++) begin
            seed = lcg_next(seed);
            ops[u] = seed[31:16];
            op_in[u*data_w +: data_w] = ops[u];
         end

         for (int u = 0; u < n_units; u++) begin
            write_cfg(u, make_cfg(test_field(t, 4*u+1), test_field(t, 4*u+2),
                                  test_field(t, 4*u+3), iters, period, delay,
                                  test_field(t, 4*u+4)));
         end

         pulse_and_wait(waited);
         checks++;
         assert (waited == exp_wait) else begin
            $display("error: %0t test %0d done after %0d cycles, expected %0d",
                     $time, id, waited, exp_wait);
            bad++;
         end

         for (int u = 0; u < n_units; u++) begin
            op = test_field(t, 4*u+3);
            p  = shifted_product(pick_op(test_field(t, 4*u+1)),
                                 pick_op(test_field(t, 4*u+2)), test_field(t, 4*u+4));
            if (iters != 0 && period != 0) begin
               case (op)
                  0:       exp_acc[u] = p * period;
                  1:       exp_acc[u] = p * (2 - period);   // reload then subtract the rest
                  default: exp_acc[u] = exp_acc[u] + p * (period * iters);
               endcase
            end
            got = result[u*data_w +: data_w];
            checks++;
            assert (got == exp_acc[u][2*data_w-1:data_w]) else begin
               $display("error: %0t test %0d unit %0d result %h, expected %h",
                        $time, id, u, got, exp_acc[u][2*data_w-1:data_w]);
               bad++;
            end
         end

         errors = errors + bad;
         $display("test %0d: done after %0d cycles, %s", id, waited,
                  (bad == 0) ? "ok" : "mismatch");
      end

      errors = errors + UUT.u_chk.fails;   // bound assertion failures
      if (n_tests == 0) begin
         $display("no tests were read from the data file");
         errors++;
      end
      $display("summary: %0d tests, %0d checks, %0d failures", n_tests, checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* bench/muladd_array_chk.sv */
`default_nettype none

module muladd_array_chk (
   input logic clk,
   input logic rst,
   input logic start,
   input logic done
);

   int fails = 0;   // read back by the testbench

   // done comes out of reset low
   a_done_after_reset: assert property (@(posedge clk) $fell(rst) |-> !done)
      else begin
         $error("done is high in the cycle after reset");
         fails++;
      end

   // a restart drops done two cycles later
   a_done_falls: assert property (@(posedge clk) disable iff (rst)
      $past(start, 2) |-> !done)
      else begin
         $error("done still high two cycles after start");
         fails++;
      end

   // done holds until the next start
   a_done_holds: assert property (@(posedge clk) disable iff (rst)
      done && !start && !$past(start) |=> done)
      else begin
         $error("done dropped without a start");
         fails++;
      end

endmodule

bind muladd_array muladd_array_chk u_chk (
   .clk   (clk),
   .rst   (rst),
   .start (start),
   .done  (done)
);

`default_nettype wire

/* src/muladd_array.sv */
`default_nettype none

module muladd_array #(
   parameter int DATA_W  = 16,
   parameter int N_UNITS = 4
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       start,
   input  logic [N_UNITS*DATA_W-1:0]  op_in,
   input  logic                       cfg_wr,
   input  logic [cgra_pkg::sel_w-1:0] cfg_unit,
   input  logic [cgra_pkg::cfg_w-1:0] cfg_data,
   output logic [N_UNITS*DATA_W-1:0]  result,
   output logic                       done
);
   import cgra_pkg::*;

   logic [N_UNITS*DATA_W-1:0] flow_bus;
   logic [N_UNITS*cfg_w-1:0]  cfg_words;
   logic [N_UNITS*DATA_W-1:0] unit_out;
   logic [N_UNITS-1:0]        unit_done;

   array_feed #(
      .DATA_W  (DATA_W),
      .N_UNITS (N_UNITS)
   ) u_feed (
      .clk       (clk),
      .rst       (rst),
      .op_in     (op_in),
      .cfg_wr    (cfg_wr),
      .cfg_unit  (cfg_unit),
      .cfg_data  (cfg_data),
      .flow_bus  (flow_bus),
      .cfg_words (cfg_words)
   );

   for (genvar i = 0; i < N_UNITS; i++) begin : g_unit
      muladd_unit #(
         .DATA_W  (DATA_W),
         .N_UNITS (N_UNITS)
      ) u_unit (
         .clk       (clk),
         .rst       (rst),
         .start     (start),
         .flow_bus  (flow_bus),
         .cfg       (cfg_words[i*cfg_w +: cfg_w]),
         .unit_out  (unit_out[i*DATA_W +: DATA_W]),
         .unit_done (unit_done[i])
      );
   end

   flow_collector #(
      .DATA_W  (DATA_W),
      .N_UNITS (N_UNITS)
   ) u_collect (
      .clk       (clk),
      .rst       (rst),
      .unit_out  (unit_out),
      .unit_done (unit_done),
      .result    (result),
      .done      (done)
   );

endmodule

`default_nettype wire

/* src/flow_collector.sv */
`default_nettype none

module flow_collector #(
   parameter int DATA_W  = 16,
   parameter int N_UNITS = 4
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [N_UNITS*DATA_W-1:0] unit_out,
   input  logic [N_UNITS-1:0]        unit_done,
   output logic [N_UNITS*DATA_W-1:0] result,
   output logic                      done
);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result <= '0;
         done   <= 1'b0;
      end else begin
         result <= unit_out;
         done   <= &unit_done;   // all units finished
      end
   end

endmodule

`default_nettype wire

/* src/muladd_unit.sv */
`default_nettype none

module muladd_unit #(
   parameter int DATA_W  = 16,
   parameter int N_UNITS = 4
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       start,
   input  logic [N_UNITS*DATA_W-1:0]  flow_bus,
   input  logic [cgra_pkg::cfg_w-1:0] cfg,
   output logic [DATA_W-1:0]          unit_out,
   output logic                       unit_done
);
   import cgra_pkg::*;

   logic [sel_w-1:0]           sela;
   logic [sel_w-1:0]           selb;
   opcode_t                    opcode;
   logic [iter_w-1:0]          iterations;
   logic [period_w-1:0]        period;
   logic [period_w-1:0]        delay;
   logic [shift_w-1:0]         shift;

   logic signed [DATA_W-1:0]   op_a;
   logic signed [DATA_W-1:0]   op_b;
   logic signed [2*DATA_W-1:0] product;
   logic [2*max_data_w-1:0]    prod_sh;

   logic                       active;
   logic                       first;
   logic                       cnt_done;
   logic [1:0]                 act_d;    // lines up with the product
   logic [1:0]                 first_d;
   logic [2:0]                 done_d;

   acc_word_t                  acc;
   logic [2*max_data_w-1:0]    acc_next;

   // config fields
   assign sela       = cfg[cfg_sela_pos +: sel_w];
   assign selb       = cfg[cfg_selb_pos +: sel_w];
   assign opcode     = opcode_t'(cfg[cfg_op_pos +: op_w]);
   assign iterations = cfg[cfg_iter_pos +: iter_w];
   assign period     = cfg[cfg_period_pos +: period_w];
   assign delay      = cfg[cfg_delay_pos +: period_w];
   assign shift      = cfg[cfg_shift_pos +: shift_w];

   // operand muxes, selects past the last unit read zero
   always_comb begin
      op_a = '0;
      op_b = '0;
      for (int i = 0; i < N_UNITS; i++) begin
         if (sela == sel_w'(i)) begin
            op_a = flow_bus[i*DATA_W +: DATA_W];
         end
         if (selb == sel_w'(i)) begin
            op_b = flow_bus[i*DATA_W +: DATA_W];
         end
      end
   end

   pace_counter u_pace (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .iterations (iterations),
      .period     (period),
      .delay      (delay),
      .active     (active),
      .first      (first),
      .done       (cnt_done)
   );

   mul_pipe #(
      .DATA_W (DATA_W)
   ) u_mul (
      .clk     (clk),
      .rst     (rst),
      .op_a    (op_a),
      .op_b    (op_b),
      .product (product)
   );

   assign prod_sh = product << shift;

   always_comb begin
      case (opcode)
         macc:    acc_next = first_d[1] ? prod_sh : acc.whole + prod_sh;
         msub:    acc_next = first_d[1] ? prod_sh : acc.whole - prod_sh;
         default: acc_next = acc.whole + prod_sh;   // never reloads
      endcase
   end

   // control delay lines
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         act_d   <= '0;
         first_d <= '0;
         done_d  <= '0;
      end else begin
         act_d   <= {act_d[0], active};
         first_d <= {first_d[0], first};
         if (start) begin
            done_d <= '0;   // drop done right away on restart
         end else begin
            done_d <= {done_d[1:0], cnt_done};
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc.whole <= '0;
      end else if (act_d[1]) begin
         acc.whole <= acc_next;
      end
   end

   assign unit_out  = acc.half.hi;
   assign unit_done = done_d[2];

endmodule

`default_nettype wire

/* src/mul_pipe.sv */
`default_nettype none

module mul_pipe #(
   parameter int DATA_W = 16
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic signed [DATA_W-1:0]   op_a,
   input  logic signed [DATA_W-1:0]   op_b,
   output logic signed [2*DATA_W-1:0] product
);

   logic signed [DATA_W-1:0] a_r;
   logic signed [DATA_W-1:0] b_r;

   // input regs then output reg to match the DSP pipeline
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         a_r     <= '0;
         b_r     <= '0;
         product <= '0;
      end else begin
         a_r     <= op_a;
         b_r     <= op_b;
         product <= (2*DATA_W)'(a_r) * (2*DATA_W)'(b_r);   // full signed product
      end
   end

endmodule

`default_nettype wire

/* src/pace_counter.sv */
`default_nettype none

module pace_counter (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          start,
   input  logic [cgra_pkg::iter_w-1:0]   iterations,
   input  logic [cgra_pkg::period_w-1:0] period,
   input  logic [cgra_pkg::period_w-1:0] delay,
   output logic                          active,
   output logic                          first,
   output logic                          done
);
   import cgra_pkg::*;

   localparam logic [1:0] s_idle = 2'd0;
   localparam logic [1:0] s_wait = 2'd1;
   localparam logic [1:0] s_run  = 2'd2;
   localparam logic [1:0] s_fin  = 2'd3;

   logic [1:0]          state;
   logic [period_w-1:0] dcnt;   // delay countdown
   logic [period_w-1:0] pidx;   // position inside the period
   logic [iter_w-1:0]   icnt;   // finished periods
   logic                empty;

   // nothing to run, only the delay is honoured
   assign empty = (iterations == '0) || (period == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= s_idle;
         dcnt  <= '0;
         pidx  <= '0;
         icnt  <= '0;
      end else if (start) begin
         pidx <= '0;
         icnt <= '0;
         if (delay != '0) begin
            state <= s_wait;
            dcnt  <= delay - period_w'(1);
         end else if (empty) begin
            state <= s_fin;
         end else begin
            state <= s_run;
         end
      end else begin
         case (state)
            s_wait: begin
               if (dcnt == '0) begin
                  state <= empty ? s_fin : s_run;
               end else begin
                  dcnt <= dcnt - period_w'(1);
               end
            end
            s_run: begin
               if (pidx == period - period_w'(1)) begin
                  pidx <= '0;
                  if (icnt == iterations - iter_w'(1)) begin
                     state <= s_fin;   // last active cycle
                  end else begin
                     icnt <= icnt + iter_w'(1);
                  end
               end else begin
                  pidx <= pidx + period_w'(1);
               end
            end
            default: begin
               // idle and finished wait for start
            end
         endcase
      end
   end

   assign active = (state == s_run);
   assign first  = active && (pidx == '0);   // accumulator reload point
   assign done   = (state == s_fin);

endmodule

`default_nettype wire

/* src/array_feed.sv */
`default_nettype none

module array_feed #(
   parameter int DATA_W  = 16,
   parameter int N_UNITS = 4
) (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic [N_UNITS*DATA_W-1:0]            op_in,
   input  logic                                 cfg_wr,
   input  logic [cgra_pkg::sel_w-1:0]           cfg_unit,
   input  logic [cgra_pkg::cfg_w-1:0]           cfg_data,
   output logic [N_UNITS*DATA_W-1:0]            flow_bus,
   output logic [N_UNITS*cgra_pkg::cfg_w-1:0]   cfg_words
);
   import cgra_pkg::*;

   // operand words onto the flow bus, one cycle late
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         flow_bus <= '0;
      end else begin
         flow_bus <= op_in;
      end
   end

   // one config register per unit
   // zero iterations after reset keeps every unit idle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg_words <= '0;
      end else if (cfg_wr) begin
         for (int i = 0; i < N_UNITS; i++) begin
            if (cfg_unit == sel_w'(i)) begin
               cfg_words[i*cfg_w +: cfg_w] <= cfg_data;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* src/cgra_pkg.sv */
`default_nettype none

package cgra_pkg;

   // widest data word the accumulator union is built for
   localparam int max_data_w = 16;

   localparam int sel_w    = 2;   // operand select, up to 4 units
   localparam int op_w     = 2;
   localparam int period_w = 4;   // period and delay
   localparam int iter_w   = 6;
   localparam int shift_w  = 4;

   typedef enum logic [op_w-1:0] {
      macc = 2'd0,
      msub = 2'd1
   } opcode_t;

   // config word layout, fields packed from the top bit down:
   // sela, selb, opcode, iterations, period, delay, shift
   localparam int cfg_shift_pos  = 0;
   localparam int cfg_delay_pos  = cfg_shift_pos + shift_w;
   localparam int cfg_period_pos = cfg_delay_pos + period_w;
   localparam int cfg_iter_pos   = cfg_period_pos + period_w;
   localparam int cfg_op_pos     = cfg_iter_pos + iter_w;
   localparam int cfg_selb_pos   = cfg_op_pos + op_w;
   localparam int cfg_sela_pos   = cfg_selb_pos + sel_w;
   localparam int cfg_w          = cfg_sela_pos + sel_w;

   typedef struct packed {
      logic [max_data_w-1:0] hi;
      logic [max_data_w-1:0] lo;
   } acc_halves_t;

   // accumulator, seen whole by the adder and split for the output
   typedef union packed {
      logic [2*max_data_w-1:0] whole;
      acc_halves_t             half;
   } acc_word_t;

endpackage

`default_nettype wire
